// File: rtl/bus_register_bridge.sv
`include "dma_settings.svh"

module bus_register_bridge import dma_pkg::*; (
    input  logic                           clock,
    input  logic                           reset,
    input  logic                           bus_write_strobe,
    input  logic [`DMA_BUS_ADDR_WIDTH-1:0] bus_write_address,
    input  bus_word_t                      bus_write_data,
    output logic                           bus_write_ready,
    input  logic                           bus_read_strobe,
    input  logic [`DMA_BUS_ADDR_WIDTH-1:0] bus_read_address,
    output logic                           bus_read_ready,
    output logic                           bus_read_valid,
    output bus_word_t                      bus_read_data,
    output logic                           write_index_valid,
    output bus_word_t                      write_index,
    output bus_word_t                      write_word,
    input  logic                           write_index_ready,
    output logic                           read_index_valid,
    output bus_word_t                      read_index,
    input  logic                           read_index_ready,
    input  logic                           read_reply_valid,
    input  bus_word_t                      read_reply_word
);

    bus_word_t write_offset;
    bus_word_t read_offset;

    // Byte offset inside the endpoint window
    assign write_offset = bus_word_t'(bus_write_address - `DMA_BASE_ADDRESS);
    assign read_offset = bus_word_t'(bus_read_address - `DMA_BASE_ADDRESS);

    // A slot accepts a new request when it is empty or is emptied in this cycle
    assign bus_write_ready = !write_index_valid || write_index_ready;
    assign bus_read_ready = !read_index_valid || read_index_ready;

    always_ff @(posedge clock) begin
        if (!reset) begin
            write_index_valid <= 1'b0;
            read_index_valid <= 1'b0;
        end else begin
            if (bus_write_ready) begin
                write_index_valid <= bus_write_strobe;
            end
            if (bus_read_ready) begin
                read_index_valid <= bus_read_strobe;
            end
        end
    end

    // Index and data only load together with a counted strobe
    always_ff @(posedge clock) begin
        if (bus_write_ready && bus_write_strobe) begin
            write_index <= write_offset >> 2;
            write_word <= bus_write_data;
        end
        if (bus_read_ready && bus_read_strobe) begin
            read_index <= read_offset >> 2;
        end
    end

    // Replies need no buffering, the bus waits for each one
    assign bus_read_valid = read_reply_valid;
    assign bus_read_data = read_reply_word;

endmodule

// File: rtl/core_register_file.sv
`include "dma_settings.svh"

module core_register_file import dma_pkg::*; (
    input  logic      clock,
    input  logic      reset,
    input  logic      write_enable,
    input  reg_addr_t write_address,
    input  reg_data_t write_data,
    input  reg_addr_t read_address,
    output reg_data_t read_data
);

    localparam int REGISTER_COUNT = 2 ** `DMA_REG_ADDR_WIDTH;

    reg_data_t registers [REGISTER_COUNT];

    // Read address sampled at each edge, data follows from storage
    reg_addr_t read_address_q;

    always_ff @(posedge clock) begin
        if (!reset) begin
            for (int i = 0; i < REGISTER_COUNT; i++) begin
                registers[i] <= '0;
            end
            read_address_q <= '0;
        end else begin
            if (write_enable) begin
                registers[write_address] <= write_data;
            end
            read_address_q <= read_address;
        end
    end

    // A write to the word being read shows up in the next cycle
    assign read_data = registers[read_address_q];

endmodule

// File: rtl/dma_endpoint.sv
`include "dma_settings.svh"

module dma_endpoint import dma_pkg::*; (
    input  logic           clock,
    input  logic           reset,
    input  logic           write_index_valid,
    input  bus_word_t      write_index,
    input  bus_word_t      write_word,
    output logic           write_index_ready,
    input  logic           read_index_valid,
    input  bus_word_t      read_index,
    output logic           read_index_ready,
    output logic           read_reply_valid,
    output bus_word_t      read_reply_word,
    input  logic           dma_write_valid,
    input  table_index_t   dma_write_channel,
    input  reg_data_t      dma_write_data,
    input  logic           dma_request_valid,
    input  table_index_t   dma_request_channel,
    output logic           dma_request_ready,
    output logic           dma_response_valid,
    output reg_data_t      dma_response_data,
    output logic           rf_write_enable,
    output reg_addr_t      rf_write_address,
    output reg_data_t      rf_write_data,
    output reg_addr_t      rf_read_address,
    input  reg_data_t      rf_read_data,
    output channel_count_t channel_count
);

    // Bus words 3 up to this limit map onto table entries 1 and up
    localparam int TABLE_WORD_LIMIT = `DMA_TABLE_DEPTH + 2;

    reg_addr_t    translation_table [`DMA_TABLE_DEPTH];
    table_index_t table_address;
    read_state_t  state;

    logic         dma_write_live;
    logic         bus_write_taken;
    logic         write_is_register;
    table_index_t write_entry;

    logic         read_is_register;
    table_index_t read_entry;
    bus_word_t    config_read_word;
    bus_word_t    config_word;
    logic         reply_from_register;

    // A DMA write wins the single register file write port
    assign write_index_ready = !dma_write_valid;

    assign dma_write_live = dma_write_valid && (dma_write_channel != '0);
    assign bus_write_taken = write_index_valid && write_index_ready;

    assign write_is_register = (write_index > word_table_data) &&
                               (write_index < bus_word_t'(TABLE_WORD_LIMIT));
    assign write_entry = table_index_t'(write_index - 32'd2);

    always_ff @(posedge clock) begin
        if (!reset) begin
            rf_write_enable <= 1'b0;
            channel_count <= '0;
            table_address <= '0;
            for (int i = 0; i < `DMA_TABLE_DEPTH; i++) begin
                translation_table[i] <= reg_addr_t'(i);
            end
        end else begin
            rf_write_enable <= dma_write_live;
            if (bus_write_taken) begin
                case (write_index)
                    word_channel_count: channel_count <= channel_count_t'(write_word);
                    word_table_address: table_address <= table_index_t'(write_word);
                    word_table_data: begin
                        translation_table[table_address] <= reg_addr_t'(write_word);
                    end
                    default: rf_write_enable <= write_is_register;
                endcase
            end
        end
    end

    // The enable alone decides whether this word lands
    always_ff @(posedge clock) begin
        if (dma_write_valid) begin
            rf_write_address <= translation_table[dma_write_channel];
            rf_write_data <= dma_write_data;
        end else begin
            rf_write_address <= translation_table[write_entry];
            rf_write_data <= reg_data_t'(write_word);
        end
    end

    // Both readies are up only while the FSM is idle, and the DMA side goes first
    assign dma_request_ready = (state == idle);
    assign read_index_ready = (state == idle) && !dma_request_valid;

    assign read_is_register = (read_index > word_table_data) &&
                              (read_index < bus_word_t'(TABLE_WORD_LIMIT));
    assign read_entry = table_index_t'(read_index - 32'd2);

    always_comb begin
        case (read_index)
            word_channel_count: config_read_word = bus_word_t'(channel_count);
            word_table_address: config_read_word = bus_word_t'(table_address);
            word_table_data: begin
                config_read_word = bus_word_t'(translation_table[table_address]);
            end
            default: config_read_word = '0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            state <= idle;
            dma_response_valid <= 1'b0;
            read_reply_valid <= 1'b0;
        end else begin
            dma_response_valid <= 1'b0;
            read_reply_valid <= 1'b0;
            case (state)
                idle: begin
                    // Channel 0 requests are taken and then forgotten
                    if (dma_request_valid) begin
                        if (dma_request_channel != '0) begin
                            state <= wait_read;
                        end
                    end else if (read_index_valid) begin
                        state <= bus_read;
                    end
                end
                wait_read: begin
                    state <= stream_read;
                end
                stream_read: begin
                    dma_response_valid <= 1'b1;
                    state <= idle;
                end
                bus_read: begin
                    read_reply_valid <= 1'b1;
                    state <= idle;
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    // Register file data is valid two cycles after the address is launched here
    always_ff @(posedge clock) begin
        if (state == idle) begin
            if (dma_request_valid) begin
                rf_read_address <= translation_table[dma_request_channel];
            end else if (read_index_valid) begin
                rf_read_address <= translation_table[read_entry];
                reply_from_register <= read_is_register;
                config_word <= config_read_word;
            end
        end
        if (state == stream_read) begin
            dma_response_data <= rf_read_data;
        end
    end

    // Register data arrives together with the reply pulse
    assign read_reply_word = reply_from_register ? bus_word_t'(rf_read_data) : config_word;

endmodule

// File: rtl/dma_pkg.sv
`include "dma_settings.svh"

package dma_pkg;

    typedef logic [`DMA_DATA_WIDTH-1:0] reg_data_t;
    typedef logic [`DMA_REG_ADDR_WIDTH-1:0] reg_addr_t;
    typedef logic [$clog2(`DMA_TABLE_DEPTH)-1:0] table_index_t;
    typedef logic [31:0] bus_word_t;
    typedef logic [2:0] channel_count_t;

    // Read FSM of the endpoint
    typedef enum logic [1:0] {
        idle,
        bus_read,
        wait_read,
        stream_read
    } read_state_t;

    // Word offsets of the configuration registers on the bus
    localparam bus_word_t word_channel_count = 32'd0;
    localparam bus_word_t word_table_address = 32'd1;
    localparam bus_word_t word_table_data = 32'd2;

endpackage

// File: rtl/dma_settings.svh
`ifndef DMA_SETTINGS_SVH
`define DMA_SETTINGS_SVH

// Width of one register word in the core datapath
`define DMA_DATA_WIDTH 20

// Register file address width, the file holds 2^N words
`define DMA_REG_ADDR_WIDTH 8

// Entries in the I/O translation table
`define DMA_TABLE_DEPTH 64

// Bus byte address width
`define DMA_BUS_ADDR_WIDTH 32

// Byte address of bus word 0 of the endpoint
`define DMA_BASE_ADDRESS 32'h43c0_0000

`endif

// File: rtl/dma_subsystem.sv
`include "dma_settings.svh"

module dma_subsystem import dma_pkg::*; (
    input  logic                           clock,
    input  logic                           reset,
    input  logic                           bus_write_strobe,
    input  logic [`DMA_BUS_ADDR_WIDTH-1:0] bus_write_address,
    input  bus_word_t                      bus_write_data,
    output logic                           bus_write_ready,
    input  logic                           bus_read_strobe,
    input  logic [`DMA_BUS_ADDR_WIDTH-1:0] bus_read_address,
    output logic                           bus_read_ready,
    output logic                           bus_read_valid,
    output bus_word_t                      bus_read_data,
    input  logic                           dma_write_valid,
    input  table_index_t                   dma_write_channel,
    input  reg_data_t                      dma_write_data,
    input  logic                           dma_request_valid,
    input  table_index_t                   dma_request_channel,
    output logic                           dma_request_ready,
    output logic                           dma_response_valid,
    output reg_data_t                      dma_response_data,
    output channel_count_t                 channel_count
);

    // Bridge to endpoint
    logic      write_index_valid;
    bus_word_t write_index;
    bus_word_t write_word;
    logic      write_index_ready;
    logic      read_index_valid;
    bus_word_t read_index;
    logic      read_index_ready;
    logic      read_reply_valid;
    bus_word_t read_reply_word;

    // Endpoint to register file
    logic      rf_write_enable;
    reg_addr_t rf_write_address;
    reg_data_t rf_write_data;
    reg_addr_t rf_read_address;
    reg_data_t rf_read_data;

    bus_register_bridge u_bus_register_bridge (
        .clock             (clock),
        .reset             (reset),
        .bus_write_strobe  (bus_write_strobe),
        .bus_write_address (bus_write_address),
        .bus_write_data    (bus_write_data),
        .bus_write_ready   (bus_write_ready),
        .bus_read_strobe   (bus_read_strobe),
        .bus_read_address  (bus_read_address),
        .bus_read_ready    (bus_read_ready),
        .bus_read_valid    (bus_read_valid),
        .bus_read_data     (bus_read_data),
        .write_index_valid (write_index_valid),
        .write_index       (write_index),
        .write_word        (write_word),
        .write_index_ready (write_index_ready),
        .read_index_valid  (read_index_valid),
        .read_index        (read_index),
        .read_index_ready  (read_index_ready),
        .read_reply_valid  (read_reply_valid),
        .read_reply_word   (read_reply_word)
    );

    dma_endpoint u_dma_endpoint (
        .clock               (clock),
        .reset               (reset),
        .write_index_valid   (write_index_valid),
        .write_index         (write_index),
        .write_word          (write_word),
        .write_index_ready   (write_index_ready),
        .read_index_valid    (read_index_valid),
        .read_index          (read_index),
        .read_index_ready    (read_index_ready),
        .read_reply_valid    (read_reply_valid),
        .read_reply_word     (read_reply_word),
        .dma_write_valid     (dma_write_valid),
        .dma_write_channel   (dma_write_channel),
        .dma_write_data      (dma_write_data),
        .dma_request_valid   (dma_request_valid),
        .dma_request_channel (dma_request_channel),
        .dma_request_ready   (dma_request_ready),
        .dma_response_valid  (dma_response_valid),
        .dma_response_data   (dma_response_data),
        .rf_write_enable     (rf_write_enable),
        .rf_write_address    (rf_write_address),
        .rf_write_data       (rf_write_data),
        .rf_read_address     (rf_read_address),
        .rf_read_data        (rf_read_data),
        .channel_count       (channel_count)
    );

    core_register_file u_core_register_file (
        .clock         (clock),
        .reset         (reset),
        .write_enable  (rf_write_enable),
        .write_address (rf_write_address),
        .write_data    (rf_write_data),
        .read_address  (rf_read_address),
        .read_data     (rf_read_data)
    );

endmodule

// File: run_sim.sh
#!/bin/sh
verilator --binary --timing --assert --top-module dma_subsystem_tb -f verilog.f -o dma_sim \
    || exit 1
./obj_dir/dma_sim > sim.log 2>&1 || echo "** FAIL **" >> sim.log
cat sim.log
grep -q '\*\* FAIL \*\*' sim.log && exit 1 || exit 0

// File: verif/dma_subsystem_assert.sv
module dma_subsystem_assert import dma_pkg::*; (
    input logic         clock,
    input logic         reset,
    input logic         read_index_valid,
    input logic         dma_request_valid,
    input table_index_t dma_request_channel,
    input logic         dma_request_ready,
    input logic         dma_response_valid,
    input logic         read_index_ready,
    input logic         dma_write_valid,
    input table_index_t dma_write_channel,
    input logic         rf_write_enable
);

    // An accepted request for a real channel, channel 0 never gets an answer
    logic request_live;
    logic bus_read_taken;
    logic readies_low;

    assign request_live = dma_request_valid && dma_request_ready && (dma_request_channel != '0);
    assign bus_read_taken = read_index_valid && read_index_ready;
    assign readies_low = !dma_request_ready && !read_index_ready;

    response_after_request: assert property (@(posedge clock) disable iff (!reset)
        $past(request_live, 3) |-> dma_response_valid)
        else $error("DMA response missing three cycles after an accepted request");

    response_has_request: assert property (@(posedge clock) disable iff (!reset)
        dma_response_valid |-> $past(request_live, 3))
        else $error("DMA response without an accepted request three cycles before");

    response_single_cycle: assert property (@(posedge clock) disable iff (!reset)
        dma_response_valid |=> !dma_response_valid)
        else $error("DMA response held longer than one cycle");

    // A DMA read stays in flight for two cycles after it is taken, a bus read for one
    readies_low_in_dma_read: assert property (@(posedge clock) disable iff (!reset)
        ($past(request_live) || $past(request_live, 2)) |-> readies_low)
        else $error("Read ready high while a DMA read is in flight");

    readies_low_in_bus_read: assert property (@(posedge clock) disable iff (!reset)
        $past(bus_read_taken) |-> readies_low)
        else $error("Read ready high while a bus read is in flight");

    channel_zero_no_write: assert property (@(posedge clock) disable iff (!reset)
        (dma_write_valid && (dma_write_channel == '0)) |=> !rf_write_enable)
        else $error("Register file written after a DMA write to channel 0");

endmodule

bind dma_endpoint dma_subsystem_assert u_dma_subsystem_assert (
    .clock               (clock),
    .reset               (reset),
    .read_index_valid    (read_index_valid),
    .dma_request_valid   (dma_request_valid),
    .dma_request_channel (dma_request_channel),
    .dma_request_ready   (dma_request_ready),
    .dma_response_valid  (dma_response_valid),
    .read_index_ready    (read_index_ready),
    .dma_write_valid     (dma_write_valid),
    .dma_write_channel   (dma_write_channel),
    .rf_write_enable     (rf_write_enable)
);

// File: verif/dma_subsystem_tb.sv
`include "dma_settings.svh"

module dma_subsystem_tb import dma_pkg::*; ();

    localparam int RESET_CYCLES = 5;
    localparam int WAIT_LIMIT = 8;
    // Replies show on the second falling edge after the one that drops the request
    localparam int REPLY_EDGES = 2;
    localparam int TABLE_WORDS_END = `DMA_TABLE_DEPTH + 2;
    // The tests issue about 45 operations, each bounded by two waits and its drive cycles
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + 48 * (2 * WAIT_LIMIT + 4);

    logic                           clock = 1'b0;
    logic                           reset;
    logic                           bus_write_strobe;
    logic [`DMA_BUS_ADDR_WIDTH-1:0] bus_write_address;
    bus_word_t                      bus_write_data;
    logic                           bus_write_ready;
    logic                           bus_read_strobe;
    logic [`DMA_BUS_ADDR_WIDTH-1:0] bus_read_address;
    logic                           bus_read_ready;
    logic                           bus_read_valid;
    bus_word_t                      bus_read_data;
    logic                           dma_write_valid;
    table_index_t                   dma_write_channel;
    reg_data_t                      dma_write_data;
    logic                           dma_request_valid;
    table_index_t                   dma_request_channel;
    logic                           dma_request_ready;
    logic                           dma_response_valid;
    reg_data_t                      dma_response_data;
    channel_count_t                 channel_count;

    // Scoreboard copy of the endpoint state and the register file
    reg_addr_t      table_model [`DMA_TABLE_DEPTH];
    reg_data_t      register_model [2 ** `DMA_REG_ADDR_WIDTH];
    channel_count_t channel_count_model;
    table_index_t   table_address_model;

    int check_count = 0;
    int value_errors = 0;
    int protocol_errors = 0;
    int cycle_count = 0;

    dma_subsystem u_dma_subsystem (.*);

    always #5 clock = ~clock;

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Run stopped after %0d cycles without finishing", cycle_count);
            $display("** FAIL **");
            $finish;
        end
    end

    task automatic compare(input string name, input bus_word_t got, input bus_word_t expected);
        check_count++;
        assert (got == expected) else begin
            value_errors++;
            $display("ERR %s got %h expected %h", name, got, expected);
        end
    endtask

    task automatic protocol_check(input logic condition, input string what);
        check_count++;
        assert (condition) else begin
            protocol_errors++;
            $display("Protocol error: %s", what);
        end
    endtask

    // Bus word 0 is the count, 1 the table address, 2 the window, 3 and up the registers
    function automatic bus_word_t expected_bus_word(input int word);
        bus_word_t    result;
        table_index_t entry;
        entry = table_index_t'(word - 2);
        case (word)
            0: result = bus_word_t'(channel_count_model);
            1: result = bus_word_t'(table_address_model);
            2: result = bus_word_t'(table_model[table_address_model]);
            default: begin
                if (word < TABLE_WORDS_END) begin
                    result = bus_word_t'(register_model[table_model[entry]]);
                end else begin
                    result = '0;
                end
            end
        endcase
        return result;
    endfunction

    task automatic bus_write(input int word, input bus_word_t data);
        int           waited = 0;
        table_index_t entry;
        entry = table_index_t'(word - 2);
        @(negedge clock);
        while (!bus_write_ready && waited < WAIT_LIMIT) begin
            @(negedge clock);
            waited++;
        end
        protocol_check(bus_write_ready, "bus write was never accepted");
        bus_write_strobe = 1'b1;
        bus_write_address = `DMA_BASE_ADDRESS + (bus_word_t'(word) << 2);
        bus_write_data = data;
        @(negedge clock);
        bus_write_strobe = 1'b0;
        case (word)
            0: channel_count_model = channel_count_t'(data);
            1: table_address_model = table_index_t'(data);
            2: table_model[table_address_model] = reg_addr_t'(data);
            default: begin
                if (word < TABLE_WORDS_END) begin
                    register_model[table_model[entry]] = reg_data_t'(data);
                end
            end
        endcase
    endtask

    task automatic bus_read_check(input int word);
        int waited = 0;
        @(negedge clock);
        while (!bus_read_ready && waited < WAIT_LIMIT) begin
            @(negedge clock);
            waited++;
        end
        protocol_check(bus_read_ready, "bus read was never accepted");
        bus_read_strobe = 1'b1;
        bus_read_address = `DMA_BASE_ADDRESS + (bus_word_t'(word) << 2);
        @(negedge clock);
        bus_read_strobe = 1'b0;
        waited = 0;
        while (!bus_read_valid && waited < WAIT_LIMIT) begin
            @(negedge clock);
            waited++;
        end
        protocol_check(bus_read_valid, "no bus read reply arrived");
        compare("bus_read_valid edge", bus_word_t'(waited), bus_word_t'(REPLY_EDGES));
        compare($sformatf("bus_read_data word %0d", word), bus_read_data, expected_bus_word(word));
    endtask

    task automatic dma_write(input table_index_t channel, input reg_data_t data);
        @(negedge clock);
        dma_write_valid = 1'b1;
        dma_write_channel = channel;
        dma_write_data = data;
        @(negedge clock);
        dma_write_valid = 1'b0;
        if (channel != '0) begin
            register_model[table_model[channel]] = data;
        end
    endtask

    task automatic dma_request(input table_index_t channel);
        int waited = 0;
        @(negedge clock);
        while (!dma_request_ready && waited < WAIT_LIMIT) begin
            @(negedge clock);
            waited++;
        end
        protocol_check(dma_request_ready, "DMA request was never accepted");
        dma_request_valid = 1'b1;
        dma_request_channel = channel;
        @(negedge clock);
        dma_request_valid = 1'b0;
    endtask

    task automatic dma_read_check(input table_index_t channel);
        int waited = 0;
        dma_request(channel);
        while (!dma_response_valid && waited < WAIT_LIMIT) begin
            @(negedge clock);
            waited++;
        end
        protocol_check(dma_response_valid, "no DMA response arrived");
        compare("dma_response_valid edge", bus_word_t'(waited), bus_word_t'(REPLY_EDGES));
        compare($sformatf("dma_response_data channel %0d", channel),
                bus_word_t'(dma_response_data),
                bus_word_t'(register_model[table_model[channel]]));
    endtask

    task automatic identity_map_test();
        compare("channel_count", bus_word_t'(channel_count), '0);
        protocol_check(bus_write_ready && bus_read_ready && dma_request_ready,
                       "a ready output is low after reset");
        protocol_check(!bus_read_valid && !dma_response_valid, "a valid output is high after reset");
        for (int word = 3; word <= 10; word++) begin
            bus_write(word, $urandom());
        end
        for (int channel = 1; channel <= 8; channel++) begin
            dma_read_check(table_index_t'(channel));
        end
        bus_read_check(3);
    endtask

    task automatic config_register_test();
        bus_write(0, $urandom());
        bus_write(1, 32'd37);
        bus_write(2, $urandom());
        for (int word = 0; word <= 2; word++) begin
            bus_read_check(word);
        end
        compare("channel_count", bus_word_t'(channel_count), bus_word_t'(channel_count_model));
    endtask

    // Channel 5 moves to register 200, seen through bus word 7 and DMA channel 5
    task automatic remap_test();
        bus_write(1, 32'd5);
        bus_write(2, 32'd200);
        dma_write(6'd5, reg_data_t'($urandom()));
        bus_read_check(7);
        dma_read_check(6'd5);
        // Back to identity, register 5 still holds the word it had before the remap
        bus_write(2, 32'd5);
        bus_read_check(7);
    endtask

    // First DMA write meets the bus strobe, the second one makes the bridge hold word 22
    task automatic collision_test();
        bus_word_t bus_data;
        reg_data_t first_data;
        reg_data_t second_data;
        bus_data = $urandom();
        first_data = reg_data_t'($urandom());
        second_data = reg_data_t'($urandom());
        @(negedge clock);
        bus_write_strobe = 1'b1;
        bus_write_address = `DMA_BASE_ADDRESS + (32'd22 << 2);
        bus_write_data = bus_data;
        dma_write_valid = 1'b1;
        dma_write_channel = 6'd12;
        dma_write_data = first_data;
        @(negedge clock);
        bus_write_strobe = 1'b0;
        dma_write_channel = 6'd13;
        dma_write_data = second_data;
        #1;
        compare("bus_write_ready", bus_word_t'(bus_write_ready), '0);
        @(negedge clock);
        dma_write_valid = 1'b0;
        register_model[table_model[6'd12]] = first_data;
        register_model[table_model[6'd13]] = second_data;
        register_model[table_model[6'd20]] = reg_data_t'(bus_data);
        dma_read_check(6'd12);
        bus_read_check(22);
        dma_read_check(6'd13);
    endtask

    task automatic channel_zero_test();
        dma_write(6'd0, reg_data_t'($urandom()));
        dma_request(6'd0);
        protocol_check(dma_request_ready, "a channel 0 request left the read FSM busy");
        repeat (5) begin
            @(negedge clock);
            protocol_check(!dma_response_valid, "a DMA response arrived for channel 0");
        end
        for (int channel = 1; channel <= 8; channel++) begin
            dma_read_check(table_index_t'(channel));
        end
    endtask

    initial begin
        void'($urandom(32'h874ff5f1));
        reset = 1'b0;
        bus_write_strobe = 1'b0;
        bus_write_address = `DMA_BASE_ADDRESS;
        bus_write_data = '0;
        bus_read_strobe = 1'b0;
        bus_read_address = `DMA_BASE_ADDRESS;
        dma_write_valid = 1'b0;
        dma_write_channel = '0;
        dma_write_data = '0;
        dma_request_valid = 1'b0;
        dma_request_channel = '0;
        channel_count_model = '0;
        table_address_model = '0;
        for (int i = 0; i < `DMA_TABLE_DEPTH; i++) begin
            table_model[table_index_t'(i)] = reg_addr_t'(i);
        end
        for (int i = 0; i < 2 ** `DMA_REG_ADDR_WIDTH; i++) begin
            register_model[reg_addr_t'(i)] = '0;
        end
        repeat (RESET_CYCLES) @(negedge clock);
        reset = 1'b1;
        identity_map_test();
        config_register_test();
        remap_test();
        collision_test();
        channel_zero_test();
        $display("Checks: %0d, value errors: %0d, protocol errors: %0d",
                 check_count, value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+rtl
rtl/dma_pkg.sv
rtl/bus_register_bridge.sv
rtl/dma_endpoint.sv
rtl/core_register_file.sv
rtl/dma_subsystem.sv
verif/dma_subsystem_assert.sv
verif/dma_subsystem_tb.sv
